// ==== sources.f ====
+incdir+hdl
hdl/bt_link_pkg.sv
hdl/stream_fifo_bank.sv
hdl/stream_scheduler.sv
hdl/uart_tx.sv
hdl/tx_sequencer.sv
hdl/bt_link_top.sv
testbench/bt_link_asserts.sv
testbench/bt_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -f "$LOG" \
	&& verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f sources.f --top-module bt_link_tb --Mdir obj_dir -o bt_link_sim \
	&& ./obj_dir/bt_link_sim 2>&1 | tee "$LOG"

grep -q "^Result: PASSED$" "$LOG" && exit 0 || { echo "Simulation failed, see $LOG"; exit 1; }

// ==== testbench/bt_link_tb.sv ====
`default_nettype none

`include "bt_link_config.svh"

module bt_link_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import bt_link_pkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int CPB = 4;
	localparam int SPACING = 6;
	localparam int BIT_TIME = CLOCK_PERIOD * CPB;
	localparam int ACK_LIMIT = 16;
	// Words sent over all tests, with slack for bus traffic and idle windows
	localparam int TOTAL_WORDS = 17;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 2 * (10 * CPB + SPACING + 20) + 1000;

	logic        clock;
	logic        reset;
	logic        link_enable;
	timer_t      cycles_per_bit;
	timer_t      char_spacing;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	stream_sel_t wb_adr;
	word_t       wb_dat_w;
	logic        wb_ack;
	word_t       wb_dat_r;
	logic        bt_txd;

	int          seed = 32'hde1b_f262;
	char_t       rx_chars[$];
	time         rx_falls[$];
	word_t       expected_words[$];

	bt_link_top bt_link_top_inst (
		.clock, .reset, .link_enable, .cycles_per_bit, .char_spacing,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .wb_dat_r, .bt_txd
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic sync_to_clock();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic bus_request(input logic we, input stream_sel_t adr, input word_t data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = data;
	endtask

	task automatic bus_release();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wait_for_ack(input int max_cycles, output logic acked);
		acked = 1'b0;
		for (int n = 0; n < max_cycles && !acked; n++)
		begin
			sync_to_clock();
			acked = wb_ack;
		end
	endtask

	task automatic bus_transfer(input logic we, input stream_sel_t adr, input word_t data,
		output word_t rdata);
		logic acked;
		bus_request(we, adr, data);
		wait_for_ack(ACK_LIMIT, acked);
		if (!acked)
		begin
			$display("Error at %0d ns: no wb_ack for the access to stream %0d", $time, adr);
			stop_with_failure();
		end
		rdata = wb_dat_r;
		bus_release();
	endtask

	task automatic write_word(input stream_sel_t adr, input word_t data);
		word_t unused;
		bus_transfer(1'b1, adr, data, unused);
	endtask

	task automatic read_level(input stream_sel_t adr, output word_t level);
		bus_transfer(1'b0, adr, '0, level);
	endtask

	// 8N1 decoder, sampled mid-bit
	task automatic receive_char();
		char_t ch;
		time   fall;
		@(negedge bt_txd);
		fall = $time;
		#(BIT_TIME / 2);
		check_value("bt_txd start bit", bt_txd, 0);
		for (int b = 0; b < `BT_CHAR_W; b++)
		begin
			#(BIT_TIME);
			ch[b] = bt_txd;
		end
		#(BIT_TIME);
		check_value("bt_txd stop bit", bt_txd, 1);
		rx_chars.push_back(ch);
		rx_falls.push_back(fall);
	endtask

	task automatic receive_chars(input int count);
		repeat (count) receive_char();
	endtask

	task automatic clear_capture();
		rx_chars.delete();
		rx_falls.delete();
		expected_words.delete();
	endtask

	// Characters in word order, then the idle gap after every stop bit
	task automatic check_received();
		int gap;
		check_value("received character count", rx_chars.size(), expected_words.size() * 2);
		foreach (expected_words[i])
		begin
			check_value($sformatf("bt_txd character %0d", 2 * i), rx_chars[2 * i],
				char_t'(expected_words[i] >> `BT_CHAR_W));
			check_value($sformatf("bt_txd character %0d", 2 * i + 1), rx_chars[2 * i + 1],
				char_t'(expected_words[i]));
		end
		for (int i = 1; i < rx_falls.size(); i++)
		begin
			gap = int'((rx_falls[i] - rx_falls[i - 1]) / CLOCK_PERIOD) - 10 * CPB;
			if (i % 2 == 1)
				check_value("bt_txd idle cycles after high byte", gap, SPACING);
			else
				check_value("bt_txd idle cycles between words",
					(gap >= SPACING) ? SPACING : gap, SPACING);
		end
	endtask

	task automatic test_reset_state();
		word_t level;
		check_value("bt_txd", bt_txd, 1);
		check_value("wb_ack", wb_ack, 0);
		for (int s = 0; s < `BT_STREAMS; s++)
		begin
			read_level(stream_sel_t'(s), level);
			check_value($sformatf("wb_dat_r level of stream %0d", s), level, 0);
		end
	endtask

	task automatic test_round_robin();
		word_t w [5];
		word_t level;
		int    exp_level [4] = '{2, 0, 2, 1};
		clear_capture();
		link_enable = 1'b0;
		for (int k = 0; k < 5; k++)
			w[k] = word_t'($random(seed));
		write_word(2'd0, w[0]);
		write_word(2'd0, w[1]);
		write_word(2'd2, w[2]);
		write_word(2'd2, w[3]);
		write_word(2'd3, w[4]);
		for (int s = 0; s < `BT_STREAMS; s++)
		begin
			read_level(stream_sel_t'(s), level);
			check_value($sformatf("wb_dat_r level of stream %0d", s), level, exp_level[s]);
		end
		// Pointer starts at stream 0
		expected_words = '{w[0], w[2], w[4], w[1], w[3]};
		link_enable = 1'b1;
		receive_chars(10);
		check_received();
	endtask

	task automatic test_single_word();
		clear_capture();
		sync_to_clock();
		link_enable = 1'b1;
		expected_words.push_back(16'hA53C);
		fork
			write_word(2'd1, 16'hA53C);
			receive_chars(2);
		join
		check_received();
	endtask

	task automatic test_back_pressure();
		word_t w;
		word_t level;
		logic  acked;
		clear_capture();
		sync_to_clock();
		link_enable = 1'b0;
		repeat (20) sync_to_clock();
		for (int k = 0; k < `BT_FIFO_DEPTH; k++)
		begin
			w = word_t'($random(seed));
			expected_words.push_back(w);
			write_word(2'd1, w);
		end
		read_level(2'd1, level);
		check_value("wb_dat_r level of stream 1", level, `BT_FIFO_DEPTH);
		w = word_t'($random(seed));
		expected_words.push_back(w);
		bus_request(1'b1, 2'd1, w);
		wait_for_ack(50, acked);
		check_value("wb_ack while stream 1 is full", acked, 0);
		link_enable = 1'b1;
		fork
			begin
				wait_for_ack(ACK_LIMIT, acked);
				check_value("wb_ack after a pop", acked, 1);
				bus_release();
			end
			receive_chars(2 * (`BT_FIFO_DEPTH + 1));
		join
		check_received();
	endtask

	task automatic test_enable_gating();
		word_t w [2];
		word_t level;
		clear_capture();
		sync_to_clock();
		link_enable = 1'b0;
		repeat (20) sync_to_clock();
		w[0] = word_t'($random(seed));
		w[1] = word_t'($random(seed));
		write_word(2'd2, w[0]);
		write_word(2'd2, w[1]);
		expected_words.push_back(w[0]);
		link_enable = 1'b1;
		fork
			receive_chars(2);
			begin
				// Drop the enable while the high byte is on the line
				@(negedge bt_txd);
				repeat (3 * CPB) @(posedge clock);
				#DRIVE_DELAY link_enable = 1'b0;
			end
		join
		check_received();
		for (int n = 0; n < 200; n++)
		begin
			sync_to_clock();
			check_value("bt_txd while link_enable is low", bt_txd, 1);
		end
		read_level(2'd2, level);
		check_value("wb_dat_r level of stream 2", level, 1);
		// Held word goes out once enabled again
		clear_capture();
		expected_words.push_back(w[1]);
		link_enable = 1'b1;
		receive_chars(2);
		check_received();
	endtask

	initial
	begin
		reset = 1'b1;
		link_enable = 1'b0;
		cycles_per_bit = timer_t'(CPB);
		char_spacing = timer_t'(SPACING);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (16) @(posedge clock);
		#DRIVE_DELAY reset = 1'b0;
		test_reset_state();
		test_round_robin();
		test_single_word();
		test_back_pressure();
		test_enable_gating();
		$display("Result: PASSED");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Error: watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		stop_with_failure();
	end

endmodule

`default_nettype wire

// ==== testbench/bt_link_asserts.sv ====
`default_nettype none

module bt_link_asserts (
	input wire                            clock,
	input wire                            reset,
	input wire                            wb_ack,
	input wire                            pop,
	input wire bt_link_pkg::stream_mask_t empty_mask,
	input wire                            tx_start,
	input wire                            tx_busy,
	input wire                            bt_txd
);
	timeunit 1ns;
	timeprecision 1ps;

	// Ack is a single-cycle pulse
	ack_pulse: assert property (@(posedge clock) disable iff (reset) wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for more than one cycle");

	// Start only into an idle transmitter, which takes it at once
	start_when_idle: assert property (@(posedge clock) disable iff (reset)
		tx_start |=> $rose(tx_busy))
		else $error("tx_start was not taken by an idle transmitter");

	pop_not_empty: assert property (@(posedge clock) disable iff (reset) pop |-> !(&empty_mask))
		else $error("pop issued while every stream was empty");

	// Line rests at mark level
	idle_line_high: assert property (@(posedge clock) disable iff (reset) !tx_busy |-> bt_txd)
		else $error("bt_txd low while the transmitter was idle");

endmodule

bind bt_link_top bt_link_asserts bt_link_asserts_inst (
	.clock, .reset, .wb_ack, .pop, .empty_mask, .tx_start, .tx_busy, .bt_txd
);

`default_nettype wire

// ==== hdl/bt_link_top.sv ====
`default_nettype none

module bt_link_top (
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           link_enable,
	input  wire bt_link_pkg::timer_t      cycles_per_bit,
	input  wire bt_link_pkg::timer_t      char_spacing,
	input  wire                           wb_cyc,
	input  wire                           wb_stb,
	input  wire                           wb_we,
	input  wire bt_link_pkg::stream_sel_t wb_adr,
	input  wire bt_link_pkg::word_t       wb_dat_w,
	output logic                          wb_ack,
	output bt_link_pkg::word_t            wb_dat_r,
	output logic                          bt_txd
);
	import bt_link_pkg::*;

	stream_mask_t empty_mask;
	word_t        fifo_head;
	stream_sel_t  select;
	logic         select_valid;
	logic         pop;
	logic         advance;
	logic         tx_start;
	char_t        tx_char;
	logic         tx_busy;
	logic         tx_done;

	stream_fifo_bank stream_fifo_bank_inst (
		.clock, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.pop, .select, .wb_ack, .wb_dat_r, .empty_mask, .fifo_head
	);

	stream_scheduler stream_scheduler_inst (
		.clock, .reset, .empty_mask, .advance, .select, .select_valid
	);

	tx_sequencer tx_sequencer_inst (
		.clock, .reset, .link_enable, .select_valid, .fifo_head, .tx_busy,
		.tx_done, .char_spacing, .pop, .advance, .tx_start, .tx_char
	);

	uart_tx uart_tx_inst (
		.clock, .reset, .tx_start, .tx_char, .cycles_per_bit,
		.tx_busy, .tx_done, .txd(bt_txd)
	);

endmodule

`default_nettype wire

// ==== hdl/tx_sequencer.sv ====
`default_nettype none

`include "bt_link_config.svh"

module tx_sequencer (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      link_enable,
	input  wire                      select_valid,
	input  wire bt_link_pkg::word_t  fifo_head,
	input  wire                      tx_busy,
	input  wire                      tx_done,
	input  wire bt_link_pkg::timer_t char_spacing,
	output logic                     pop,
	output logic                     advance,
	output logic                     tx_start,
	output bt_link_pkg::char_t       tx_char
);
	import bt_link_pkg::*;

	// Idle cycles still to come after SEQ_SPACE ends, up to and including the start cycle
	localparam int unsigned LOAD_LEAD = 2;
	localparam int unsigned WORD_LEAD = 4;

	seq_state_t state;
	word_t      hold;
	logic       byte_cnt;
	timer_t     space_cnt;
	logic       space_done;

	assign pop = (state == SEQ_RELEASE);
	assign advance = (state == SEQ_RELEASE);
	assign tx_start = (state == SEQ_LOAD) && !tx_busy;

	// High byte first
	assign tx_char = byte_cnt ? char_t'(hold) : char_t'(hold >> `BT_CHAR_W);

	// The next-word path runs through SELECT and RELEASE, two more cycles
	assign space_done = byte_cnt ? (space_cnt + WORD_LEAD >= char_spacing)
		: (space_cnt + LOAD_LEAD >= char_spacing);

	always_ff @(posedge clock)
	begin
		if (state == SEQ_RELEASE)
			hold <= fifo_head;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			byte_cnt <= 1'b0;
			space_cnt <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (link_enable)
						state <= SEQ_SELECT;
				end
				SEQ_SELECT:
				begin
					if (!link_enable)
						state <= SEQ_IDLE;
					else if (select_valid)
						state <= SEQ_RELEASE;
				end
				SEQ_RELEASE:
				begin
					byte_cnt <= 1'b0;
					state <= SEQ_LOAD;
				end
				SEQ_LOAD:
				begin
					if (!tx_busy)
						state <= SEQ_SEND;
				end
				SEQ_SEND:
				begin
					// The tx_done cycle is already the first idle one
					if (tx_done)
					begin
						space_cnt <= timer_t'(1);
						state <= SEQ_SPACE;
					end
				end
				SEQ_SPACE:
				begin
					if (!space_done)
						space_cnt <= space_cnt + 1'b1;
					else if (!byte_cnt)
					begin
						byte_cnt <= 1'b1;
						state <= SEQ_LOAD;
					end
					else
						state <= link_enable ? SEQ_SELECT : SEQ_IDLE;
				end
				default:
					state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`default_nettype none

`include "bt_link_config.svh"

module uart_tx (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      tx_start,
	input  wire bt_link_pkg::char_t  tx_char,
	input  wire bt_link_pkg::timer_t cycles_per_bit,
	output logic                     tx_busy,
	output logic                     tx_done,
	output logic                     txd
);
	import bt_link_pkg::*;

	uart_state_t              state;
	timer_t                   bit_timer;
	char_t                    shift;
	logic [`BT_BIT_IDX_W-1:0] bit_idx;
	logic                     bit_end;

	assign tx_busy = (state != UART_IDLE);
	assign bit_end = (bit_timer == timer_t'(cycles_per_bit - 1'b1));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= UART_IDLE;
			bit_timer <= '0;
			bit_idx <= '0;
			shift <= '0;
			txd <= 1'b1;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (state == UART_IDLE)
			begin
				if (tx_start)
				begin
					shift <= tx_char;
					bit_timer <= '0;
					txd <= 1'b0;
					state <= UART_START;
				end
			end
			else if (!bit_end)
				bit_timer <= bit_timer + 1'b1;
			else
			begin
				bit_timer <= '0;
				case (state)
					UART_START:
					begin
						// LSB first
						txd <= shift[0];
						shift <= shift >> 1;
						bit_idx <= '0;
						state <= UART_DATA;
					end
					UART_DATA:
					begin
						if (bit_idx == `BT_BIT_IDX_W'(`BT_CHAR_W - 1))
						begin
							txd <= 1'b1;
							state <= UART_STOP;
						end
						else
						begin
							txd <= shift[0];
							shift <= shift >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end
					default:
					begin
						tx_done <= 1'b1;
						state <= UART_IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/stream_scheduler.sv ====
`default_nettype none

`include "bt_link_config.svh"

module stream_scheduler (
	input  wire                           clock,
	input  wire                           reset,
	input  wire bt_link_pkg::stream_mask_t empty_mask,
	input  wire                           advance,
	output bt_link_pkg::stream_sel_t      select,
	output logic                          select_valid
);
	import bt_link_pkg::*;

	stream_sel_t ptr;
	stream_sel_t next_ptr;
	stream_sel_t pick;
	logic        found;

	// Skip past the stream just served so the search sees the new pointer at once
	assign next_ptr = advance ? stream_sel_t'(select + 1'b1) : ptr;

	// First non-empty stream at or after the pointer, wrapping around
	always_comb
	begin
		stream_sel_t idx;
		found = 1'b0;
		pick = select;
		for (int k = 0; k < `BT_STREAMS; k++)
		begin
			idx = stream_sel_t'(next_ptr + k);
			if (!found && !empty_mask[idx])
			begin
				found = 1'b1;
				pick = idx;
			end
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			ptr <= '0;
			select <= '0;
			select_valid <= 1'b0;
		end
		else
		begin
			ptr <= next_ptr;
			select <= pick;
			select_valid <= found;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/stream_fifo_bank.sv ====
`default_nettype none

`include "bt_link_config.svh"

module stream_fifo_bank (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       wb_cyc,
	input  wire                       wb_stb,
	input  wire                       wb_we,
	input  wire bt_link_pkg::stream_sel_t wb_adr,
	input  wire bt_link_pkg::word_t   wb_dat_w,
	input  wire                       pop,
	input  wire bt_link_pkg::stream_sel_t select,
	output logic                      wb_ack,
	output bt_link_pkg::word_t        wb_dat_r,
	output bt_link_pkg::stream_mask_t empty_mask,
	output bt_link_pkg::word_t        fifo_head
);
	import bt_link_pkg::*;

	word_t                mem [`BT_STREAMS][`BT_FIFO_DEPTH];
	logic [`BT_PTR_W-1:0] wr_ptr [`BT_STREAMS];
	logic [`BT_PTR_W-1:0] rd_ptr [`BT_STREAMS];
	fifo_count_t          count [`BT_STREAMS];
	stream_mask_t         full_mask;
	stream_mask_t         push;
	stream_mask_t         take;
	logic                 wb_req;
	logic                 wb_accept;

	// A request still waiting, masked during its own ack cycle
	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	// Writes into a full FIFO stall until a pop frees a slot
	assign wb_accept = wb_req && (!wb_we || !full_mask[wb_adr]);

	always_comb
	begin
		for (int i = 0; i < `BT_STREAMS; i++)
		begin
			full_mask[i] = (count[i] == fifo_count_t'(`BT_FIFO_DEPTH));
			empty_mask[i] = (count[i] == '0);
			push[i] = wb_accept && wb_we && (wb_adr == stream_sel_t'(i));
			take[i] = pop && (select == stream_sel_t'(i)) && !empty_mask[i];
		end
	end

	assign fifo_head = mem[select][rd_ptr[select]];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			for (int i = 0; i < `BT_STREAMS; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				count[i] <= '0;
			end
		end
		else
		begin
			wb_ack <= wb_accept;
			for (int i = 0; i < `BT_STREAMS; i++)
			begin
				if (push[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;
				if (take[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				// Simultaneous push and pop leave the level alone
				if (push[i] && !take[i])
					count[i] <= count[i] + 1'b1;
				else if (take[i] && !push[i])
					count[i] <= count[i] - 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < `BT_STREAMS; i++)
		begin
			if (push[i])
				mem[i][wr_ptr[i]] <= wb_dat_w;
		end
		// Fill level read, zero extended
		if (wb_accept && !wb_we)
			wb_dat_r <= word_t'(count[wb_adr]);
	end

endmodule

`default_nettype wire

// ==== hdl/bt_link_pkg.sv ====
`default_nettype none

`include "bt_link_config.svh"

package bt_link_pkg;

	typedef logic [`BT_WORD_W-1:0]    word_t;
	typedef logic [`BT_CHAR_W-1:0]    char_t;
	typedef logic [`BT_SEL_W-1:0]     stream_sel_t;
	typedef logic [`BT_STREAMS-1:0]   stream_mask_t;
	// Holds 0 up to the full depth
	typedef logic [`BT_COUNT_W-1:0]   fifo_count_t;
	typedef logic [`BT_TIMER_W-1:0]   timer_t;

	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_SELECT, SEQ_RELEASE, SEQ_LOAD, SEQ_SEND, SEQ_SPACE
	} seq_state_t;

	typedef enum logic [1:0] {
		UART_IDLE, UART_START, UART_DATA, UART_STOP
	} uart_state_t;

endpackage

`default_nettype wire

// ==== hdl/bt_link_config.svh ====
`ifndef BT_LINK_CONFIG_SVH
`define BT_LINK_CONFIG_SVH

// Sensor streams and their buffering
`define BT_STREAMS      4
`define BT_FIFO_DEPTH   8

// Data widths
`define BT_WORD_W       16
`define BT_CHAR_W       8
`define BT_TIMER_W      10

// Derived index widths, kept in step with the values above
`define BT_SEL_W        2
`define BT_COUNT_W      4
`define BT_PTR_W        3
`define BT_BIT_IDX_W    3

`endif
